/* build.f */
+incdir+include
logic/bbc_mem_pkg.sv
logic/addr_decoder.sv
logic/ic32_latch.sv
logic/display_address.sv
logic/mem_access.sv
logic/bbc_mem_top.sv
tb/bbc_mem_assert.sv
tb/bbc_mem_tb.sv

/* Makefile */
# Verilator flow for the BBC memory glue testbench

VERILATOR ?= verilator
TOP       ?= bbc_mem_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/bbc_mem_tb.sv */
`timescale 1ns/1ps

`include "bbc_mem_params.svh"

module bbc_mem_tb;

   logic                      CLK32M_I;
   logic                      reset_n;
   logic [`BBC_CPU_AW-1:0]    cpu_a;
   logic [`BBC_DW-1:0]        cpu_wdata;
   logic                      cpu_r_nw;
   logic                      cpu_clken;
   logic [`BBC_DW-1:0]        cpu_rdata;
   logic                      video_clken;
   logic [`BBC_MA_W-1:0]      crtc_ma;
   logic [`BBC_RA_W-1:0]      crtc_ra;
   logic [`BBC_DW-1:0]        sys_via_pb;
   logic [`BBC_EXT_AW-1:0]    ext_a;
   logic                      ext_n_oe;
   logic                      ext_n_we;
   logic [`BBC_DW-1:0]        ext_din;
   logic [`BBC_DW-1:0]        ext_dout;
   logic                      keyb_enable_n;
   logic                      sound_enable_n;
   logic                      caps_lock_led_n;
   logic                      shift_lock_led_n;

   // Model state and what the next compare expects
   logic [31:0]               lfsr;
   logic [`BBC_ROMSEL_W-1:0]  m_romsel;
   logic [7:0]                m_ic32;
   logic [`BBC_EXT_AW-1:0]    m_ext_a;
   logic [`BBC_EXT_AW-1:0]    exp_a;
   logic [1:0]                exp_strobe;
   logic [`BBC_DW-1:0]        exp_din;
   logic [`BBC_DW-1:0]        exp_rdata;
   logic [3:0]                exp_flags;
   logic                      pending;
   int                        err_cnt;
   int                        test_err;
   int                        test_cnt;
   int                        test_fail;
   int                        check_cnt;

   bbc_mem_top u_dut (.*);

   initial
   begin
      CLK32M_I = 1'b0;
      forever #5 CLK32M_I = ~CLK32M_I;
   end

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Port B value that only touches the speech bits 1 and 2
   function automatic logic [7:0] spare_pb();
      logic [31:0] r;
      r = take_bits(2);
      return {4'h0, r[1], 1'b0, r[0], ~r[0]};
   endfunction

   function automatic bbc_mem_pkg::bus_region_e ref_region(input logic [15:0] a);
      logic sheila;
      sheila = (a[15:8] == `BBC_SHEILA_PAGE);
      if (a < `BBC_ROM_BASE)
         return bbc_mem_pkg::REGION_RAM;
      if (a < `BBC_MOS_BASE)
         return bbc_mem_pkg::REGION_ROM;
      if ((a < `BBC_FRED_BASE) || (a >= 16'hFF00))
         return bbc_mem_pkg::REGION_MOS;
      if (sheila && (a[7:0] >= 8'h08) && (a[7:0] <= 8'h0F))
         return bbc_mem_pkg::REGION_ACIA;
      if (sheila && (a[7:0] >= 8'h30) && (a[7:0] <= 8'h3F))
         return bbc_mem_pkg::REGION_ROMSEL;
      return bbc_mem_pkg::REGION_IO_OTHER;
   endfunction

   function automatic logic [`BBC_DISP_AW-1:0] ref_display_a(input logic [13:0] ma,
      input logic [4:0] ra, input bbc_mem_pkg::wrap_mode_e wrap);
      logic [3:0] nib;
      case (wrap)
         bbc_mem_pkg::WRAP_MODE3:   nib = `BBC_WRAP_MODE3;
         bbc_mem_pkg::WRAP_MODE6:   nib = `BBC_WRAP_MODE6;
         bbc_mem_pkg::WRAP_MODE012: nib = `BBC_WRAP_MODE012;
         default:                   nib = `BBC_WRAP_MODE45;
      endcase
      nib = ma[12] ? (ma[11:8] + nib) : ma[11:8];
      return ma[13] ? {nib[3], 4'b1111, ma[9:0]} : {nib, ma[7:0], ra[2:0]};
   endfunction

   function automatic logic [`BBC_EXT_AW-1:0] ref_ext_a(input logic vclk,
      input logic [`BBC_DISP_AW-1:0] disp, input bbc_mem_pkg::bus_region_e rg,
      input logic [15:0] a, input logic [`BBC_EXT_AW-1:0] prev);
      if (!vclk)
         return {3'b000, disp};
      case (rg)
         bbc_mem_pkg::REGION_ROM: return {m_romsel, a[13:0]};
         bbc_mem_pkg::REGION_RAM, bbc_mem_pkg::REGION_MOS: return {2'b00, a};
         default: return prev;
      endcase
   endfunction

   function automatic logic [`BBC_DW-1:0] ref_rdata(input bbc_mem_pkg::bus_region_e rg,
      input logic [`BBC_DW-1:0] dout);
      case (rg)
         bbc_mem_pkg::REGION_ACIA: return `BBC_ACIA_STATUS;
         bbc_mem_pkg::REGION_ROMSEL, bbc_mem_pkg::REGION_IO_OTHER: return 8'h00;
         default: return dout;
      endcase
   endfunction

   task automatic count_result(input logic ok, input string msg);
      check_cnt++;
      if (!ok)
      begin
         $display("Error at %0d ns: %s", $time, msg);
         err_cnt++;
         test_err++;
      end
   endtask

   task automatic check_addr(input string what, input logic [`BBC_EXT_AW-1:0] got,
      input logic [`BBC_EXT_AW-1:0] exp);
      count_result(got === exp, $sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   task automatic check_data(input string what, input logic [`BBC_DW-1:0] got,
      input logic [`BBC_DW-1:0] exp);
      count_result(got === exp, $sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   task automatic check_strobe(input logic n_oe, input logic n_we, input logic [1:0] exp);
      count_result({n_oe, n_we} === exp,
         $sformatf("ext_n_oe/ext_n_we is %b%b, expected %b", n_oe, n_we, exp));
   endtask

   task automatic check_flags(input logic keyb, input logic sound, input logic caps,
      input logic shift, input logic [3:0] exp);
      count_result({keyb, sound, caps, shift} === exp,
         $sformatf("keyb/sound/caps/shift is %b%b%b%b, expected %b",
                   keyb, sound, caps, shift, exp));
   endtask

   // One bus cycle on the falling edge, then note what the DUT must show
   task automatic drive_cycle(input logic vclk, input logic [15:0] a, input logic [7:0] wd,
      input logic r_nw, input logic clken, input logic [7:0] pb, input logic [13:0] ma);
      bbc_mem_pkg::bus_region_e rg;
      logic [`BBC_DISP_AW-1:0] disp;
      int n;
      n = 0;
      do
      begin
         @(negedge CLK32M_I);
         n++;
      end
      while (pending && (n < 4));
      if (pending)
      begin
         $display("Timeout, the previous cycle was never compared");
         err_cnt++;
         test_err++;
      end
      video_clken = vclk;
      cpu_a       = a;
      cpu_wdata   = wd;
      cpu_r_nw    = r_nw;
      cpu_clken   = clken;
      sys_via_pb  = pb;
      crtc_ma     = ma;
      crtc_ra     = 5'(take_bits(5));
      ext_dout    = 8'(take_bits(8));
      rg = ref_region(a);
      // Display address uses the latch before this edge updates it
      disp = ref_display_a(ma, crtc_ra, bbc_mem_pkg::wrap_mode_e'(m_ic32[5:4]));
      m_ext_a    = ref_ext_a(vclk, disp, rg, a, m_ext_a);
      exp_a      = m_ext_a;
      exp_strobe = (vclk && (rg == bbc_mem_pkg::REGION_RAM)) ? {~r_nw, r_nw} : 2'b01;
      exp_din    = wd;
      exp_rdata  = ref_rdata(rg, ext_dout);
      if ((rg == bbc_mem_pkg::REGION_ROMSEL) && !r_nw && clken)
         m_romsel = wd[3:0];
      m_ic32[pb[2:0]] = pb[3];
      exp_flags = {m_ic32[3], m_ic32[0], m_ic32[6], m_ic32[7]};
      pending   = 1'b1;
   endtask

   task automatic end_test(input string name);
      int n;
      n = 0;
      while (pending && (n < 4))
      begin
         @(posedge CLK32M_I);
         #3;
         n++;
      end
      if (pending)
      begin
         $display("Timeout, the last cycle of test %s was never compared", name);
         err_cnt++;
         test_err++;
      end
      test_cnt++;
      if (test_err != 0)
         test_fail++;
      $display("Test %0d %-8s %s, %0d errors", test_cnt, name,
               (test_err == 0) ? "passed" : "failed", test_err);
      test_err = 0;
   endtask

   // Outputs have settled after the rising edge and inputs hold until the falling edge
   always @(posedge CLK32M_I)
   begin
      #2;
      if (pending)
      begin
         check_addr("ext_a", ext_a, exp_a);
         check_strobe(ext_n_oe, ext_n_we, exp_strobe);
         check_data("ext_din", ext_din, exp_din);
         check_data("cpu_rdata", cpu_rdata, exp_rdata);
         check_flags(keyb_enable_n, sound_enable_n, caps_lock_led_n, shift_lock_led_n,
                     exp_flags);
         pending = 1'b0;
      end
   end

   initial
   begin
      logic [3:0]  bank;
      logic [15:0] addr;
      lfsr = 32'h3135e34b;
      {m_romsel, m_ic32, m_ext_a, pending} = '0;
      {err_cnt, test_err, test_cnt, test_fail, check_cnt} = '0;
      {reset_n, cpu_a, cpu_wdata, cpu_clken, crtc_ma, crtc_ra, sys_via_pb, ext_dout} = '0;
      video_clken = 1'b1;
      cpu_r_nw    = 1'b1;
      repeat (2) @(posedge CLK32M_I);
      @(negedge CLK32M_I);
      reset_n = 1'b1;

      check_addr("ext_a", ext_a, '0);
      check_strobe(ext_n_oe, ext_n_we, 2'b11);
      check_flags(keyb_enable_n, sound_enable_n, caps_lock_led_n, shift_lock_led_n, 4'h0);
      // Bank 0 shows up in the first ROM access
      drive_cycle(1'b1, {2'b10, 14'(take_bits(14))}, 8'h00, 1'b1, 1'b1, spare_pb(), 14'h0);
      end_test("reset");

      for (int m = 0; m < 4; m++)
      begin
         drive_cycle(1'b1, 16'h0000, 8'h00, 1'b1, 1'b0, {4'h0, m[0], 3'd4}, 14'h0);
         drive_cycle(1'b1, 16'h0000, 8'h00, 1'b1, 1'b0, {4'h0, m[1], 3'd5}, 14'h0);
         for (int i = 0; i < 8; i++)
            drive_cycle(1'b0, 16'(take_bits(16)), 8'(take_bits(8)), 1'(take_bits(1)), 1'b0,
                        spare_pb(), {i[0], 13'(take_bits(13))});
      end
      end_test("video");

      for (int i = 0; i < 24; i++)
         drive_cycle(1'b1, {1'b0, 15'(take_bits(15))}, 8'(take_bits(8)), 1'(take_bits(1)),
                     1'b1, spare_pb(), 14'h0);
      end_test("ram");

      for (int i = 0; i < 4; i++)
      begin
         bank = 4'(take_bits(4));
         drive_cycle(1'b1, {12'hFE3, 4'(take_bits(4))}, {4'h0, bank}, 1'b0, 1'b1,
                     spare_pb(), 14'h0);
         drive_cycle(1'b1, {2'b10, 14'(take_bits(14))}, 8'h00, 1'b1, 1'b1, spare_pb(), 14'h0);
         // No strobe, so the bank must stay
         drive_cycle(1'b1, 16'hFE30, {4'h0, ~bank}, 1'b0, 1'b0, spare_pb(), 14'h0);
         drive_cycle(1'b1, {2'b10, 14'(take_bits(14))}, 8'h00, 1'b1, 1'b1, spare_pb(), 14'h0);
      end
      end_test("romsel");

      for (int i = 0; i < 30; i++)
      begin
         if (i % 3 == 0)
            addr = {13'h1FC1, 3'(take_bits(3))};
         else if (i % 3 == 1)
            addr = {6'h3F, 10'(take_bits(10))};
         else
            addr = {2'b11, 14'(take_bits(14))};
         drive_cycle(1'b1, addr, 8'(take_bits(8)), 1'b1, 1'b1, spare_pb(), 14'h0);
      end
      end_test("mos_io");

      for (int i = 0; i < 32; i++)
         drive_cycle(1'b1, 16'h0000, 8'h00, 1'b1, 1'b0, 8'(take_bits(8)), 14'h0);
      end_test("ic32");

      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               test_cnt, test_fail, check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* tb/bbc_mem_assert.sv */
`timescale 1ns/1ps

`include "bbc_mem_params.svh"

module bbc_mem_assert
(
   input logic                        CLK32M_I,
   input logic                        reset_n,
   input logic                        video_clken,
   input bbc_mem_pkg::bus_region_e    region,
   input logic [`BBC_EXT_AW-1:0]      ext_a,
   input logic                        ext_n_oe,
   input logic                        ext_n_we
);

   // RAM never sees write and output enable together
   we_excludes_oe: assert property (@(posedge CLK32M_I) disable iff (!reset_n)
      !ext_n_we |-> ext_n_oe)
      else $error("ext_n_we and ext_n_oe are both low");

   // Screen memory lives in the bottom 32K
   video_in_low_ram: assert property (@(posedge CLK32M_I) disable iff (!reset_n)
      !video_clken |=> (ext_a[`BBC_EXT_AW-1:`BBC_DISP_AW] == '0))
      else $error("video slot address lies above 32K");

   // Only main RAM is writable
   write_only_ram: assert property (@(posedge CLK32M_I) disable iff (!reset_n)
      (region != bbc_mem_pkg::REGION_RAM) |=> ext_n_we)
      else $error("write strobe after a non-RAM region");

endmodule

bind mem_access bbc_mem_assert u_mem_assert
(
   .CLK32M_I    (CLK32M_I),
   .reset_n     (reset_n),
   .video_clken (video_clken),
   .region      (region),
   .ext_a       (ext_a),
   .ext_n_oe    (ext_n_oe),
   .ext_n_we    (ext_n_we)
);

/* logic/bbc_mem_top.sv */
`timescale 1ns/1ps

`include "bbc_mem_params.svh"

module bbc_mem_top
(
   input  logic                        CLK32M_I,
   input  logic                        reset_n,

   // CPU bus
   input  logic [`BBC_CPU_AW-1:0]      cpu_a,
   input  logic [`BBC_DW-1:0]          cpu_wdata,
   input  logic                        cpu_r_nw,
   input  logic                        cpu_clken,
   output logic [`BBC_DW-1:0]          cpu_rdata,

   // Video side
   input  logic                        video_clken,
   input  logic [`BBC_MA_W-1:0]        crtc_ma,
   input  logic [`BBC_RA_W-1:0]        crtc_ra,

   input  logic [`BBC_DW-1:0]          sys_via_pb,

   // External RAM
   output logic [`BBC_EXT_AW-1:0]      ext_a,
   output logic                        ext_n_oe,
   output logic                        ext_n_we,
   output logic [`BBC_DW-1:0]          ext_din,
   input  logic [`BBC_DW-1:0]          ext_dout,

   output logic                        keyb_enable_n,
   output logic                        sound_enable_n,
   output logic                        caps_lock_led_n,
   output logic                        shift_lock_led_n
);

   bbc_mem_pkg::bus_region_e      region;
   logic [`BBC_ROMSEL_W-1:0]      romsel;
   bbc_mem_pkg::wrap_mode_e       wrap_mode;
   logic [`BBC_DISP_AW-1:0]       display_a;

   addr_decoder u_addr_decoder
   (
      .CLK32M_I   (CLK32M_I),
      .reset_n    (reset_n),
      .cpu_a      (cpu_a),
      .cpu_wdata  (cpu_wdata),
      .cpu_r_nw   (cpu_r_nw),
      .cpu_clken  (cpu_clken),
      .region     (region),
      .romsel     (romsel)
   );

   ic32_latch u_ic32_latch
   (
      .CLK32M_I         (CLK32M_I),
      .reset_n          (reset_n),
      .sys_via_pb       (sys_via_pb),
      .keyb_enable_n    (keyb_enable_n),
      .sound_enable_n   (sound_enable_n),
      .caps_lock_led_n  (caps_lock_led_n),
      .shift_lock_led_n (shift_lock_led_n),
      .wrap_mode        (wrap_mode)
   );

   display_address u_display_address
   (
      .crtc_ma    (crtc_ma),
      .crtc_ra    (crtc_ra),
      .wrap_mode  (wrap_mode),
      .display_a  (display_a)
   );

   mem_access u_mem_access
   (
      .CLK32M_I     (CLK32M_I),
      .reset_n      (reset_n),
      .video_clken  (video_clken),
      .display_a    (display_a),
      .region       (region),
      .romsel       (romsel),
      .cpu_a        (cpu_a),
      .cpu_wdata    (cpu_wdata),
      .cpu_r_nw     (cpu_r_nw),
      .ext_dout     (ext_dout),
      .ext_a        (ext_a),
      .ext_n_oe     (ext_n_oe),
      .ext_n_we     (ext_n_we),
      .ext_din      (ext_din),
      .cpu_rdata    (cpu_rdata)
   );

endmodule

/* logic/mem_access.sv */
`timescale 1ns/1ps

`include "bbc_mem_params.svh"

module mem_access
(
   input  logic                        CLK32M_I,
   input  logic                        reset_n,
   input  logic                        video_clken,
   input  logic [`BBC_DISP_AW-1:0]     display_a,
   input  bbc_mem_pkg::bus_region_e    region,
   input  logic [`BBC_ROMSEL_W-1:0]    romsel,
   input  logic [`BBC_CPU_AW-1:0]      cpu_a,
   input  logic [`BBC_DW-1:0]          cpu_wdata,
   input  logic                        cpu_r_nw,
   input  logic [`BBC_DW-1:0]          ext_dout,
   output logic [`BBC_EXT_AW-1:0]      ext_a,
   output logic                        ext_n_oe,
   output logic                        ext_n_we,
   output logic [`BBC_DW-1:0]          ext_din,
   output logic [`BBC_DW-1:0]          cpu_rdata
);

   logic [`BBC_EXT_AW-1:0] video_ext_a;
   logic [`BBC_EXT_AW-1:0] rom_ext_a;
   logic [`BBC_EXT_AW-1:0] cpu_ext_a;

   // Screen and main RAM share the bottom of the external RAM
   assign video_ext_a = {{(`BBC_EXT_AW-`BBC_DISP_AW){1'b0}}, display_a};
   assign cpu_ext_a   = {{(`BBC_EXT_AW-`BBC_CPU_AW){1'b0}}, cpu_a};

   // Each sideways bank is a 16K page above the bank number
   assign rom_ext_a = {romsel, cpu_a[13:0]};

   // External RAM port, one registered access per cycle
   always_ff @(posedge CLK32M_I or negedge reset_n)
   begin
      if (!reset_n)
      begin
         ext_a    <= '0;
         ext_n_oe <= 1'b1;
         ext_n_we <= 1'b1;
         ext_din  <= '0;
      end
      else
      begin
         ext_din  <= cpu_wdata;
         ext_n_we <= 1'b1;
         ext_n_oe <= 1'b0;
         // Video slot wins over any CPU access
         if (!video_clken)
         begin
            ext_a <= video_ext_a;
         end
         else if (region == bbc_mem_pkg::REGION_ROM)
         begin
            ext_a <= rom_ext_a;
         end
         else if (region == bbc_mem_pkg::REGION_MOS)
         begin
            ext_a <= cpu_ext_a;
         end
         else if (region == bbc_mem_pkg::REGION_RAM)
         begin
            // RAM is the only writable region
            ext_a    <= cpu_ext_a;
            ext_n_we <= cpu_r_nw;
            ext_n_oe <= ~cpu_r_nw;
         end
      end
   end

   // CPU read data
   always_comb
   begin
      case (region)
         bbc_mem_pkg::REGION_RAM,
         bbc_mem_pkg::REGION_ROM,
         bbc_mem_pkg::REGION_MOS:
         begin
            cpu_rdata = ext_dout;
         end
         bbc_mem_pkg::REGION_ACIA:
         begin
            cpu_rdata = `BBC_ACIA_STATUS;
         end
         default:
         begin
            // Undecoded I/O reads as pulled down
            cpu_rdata = '0;
         end
      endcase
   end

endmodule

/* logic/display_address.sv */
`timescale 1ns/1ps

`include "bbc_mem_params.svh"

module display_address
(
   input  logic [`BBC_MA_W-1:0]       crtc_ma,
   input  logic [`BBC_RA_W-1:0]       crtc_ra,
   input  bbc_mem_pkg::wrap_mode_e    wrap_mode,
   output logic [`BBC_DISP_AW-1:0]    display_a
);

   logic [3:0] wrap_offset;
   logic [3:0] high_nibble;

   // Offset that brings a wrapped address back into screen memory
   always_comb
   begin
      case (wrap_mode)
         bbc_mem_pkg::WRAP_MODE3:
         begin
            wrap_offset = `BBC_WRAP_MODE3;
         end
         bbc_mem_pkg::WRAP_MODE6:
         begin
            wrap_offset = `BBC_WRAP_MODE6;
         end
         bbc_mem_pkg::WRAP_MODE012:
         begin
            wrap_offset = `BBC_WRAP_MODE012;
         end
         default:
         begin
            wrap_offset = `BBC_WRAP_MODE45;
         end
      endcase
   end

   // MA12 set means the CRTC ran past 0x8000, sum wraps modulo 16
   assign high_nibble = crtc_ma[12] ? (crtc_ma[11:8] + wrap_offset) : crtc_ma[11:8];

   always_comb
   begin
      if (!crtc_ma[13])
      begin
         // Bitmap modes, eight scan lines per character cell
         display_a = {high_nibble, crtc_ma[7:0], crtc_ra[2:0]};
      end
      else
      begin
         // Teletext, one byte per character at 0x3C00 or 0x7C00
         display_a = {high_nibble[3], 4'b1111, crtc_ma[9:0]};
      end
   end

endmodule

/* logic/ic32_latch.sv */
`timescale 1ns/1ps

`include "bbc_mem_params.svh"

module ic32_latch
(
   input  logic                      CLK32M_I,
   input  logic                      reset_n,
   input  logic [`BBC_DW-1:0]        sys_via_pb,
   output logic                      keyb_enable_n,
   output logic                      sound_enable_n,
   output logic                      caps_lock_led_n,
   output logic                      shift_lock_led_n,
   output bbc_mem_pkg::wrap_mode_e   wrap_mode
);

   logic [7:0] ic32;

   // 74LS259 style, PB2..0 address one bit and PB3 is the data
   always_ff @(posedge CLK32M_I or negedge reset_n)
   begin
      if (!reset_n)
      begin
         ic32 <= '0;
      end
      else
      begin
         ic32[sys_via_pb[2:0]] <= sys_via_pb[3];
      end
   end

   // Bit 0 gates the sound chip write
   assign sound_enable_n = ic32[0];

   // Bits 1 and 2 were the speech chip strobes, not fitted here

   // Low lets the keyboard scan itself
   assign keyb_enable_n = ic32[3];

   assign wrap_mode = bbc_mem_pkg::wrap_mode_e'(ic32[5:4]);

   // LEDs are lit when the bit is low
   assign caps_lock_led_n  = ic32[6];
   assign shift_lock_led_n = ic32[7];

endmodule

/* logic/addr_decoder.sv */
`timescale 1ns/1ps

`include "bbc_mem_params.svh"

module addr_decoder
(
   input  logic                          CLK32M_I,
   input  logic                          reset_n,
   input  logic [`BBC_CPU_AW-1:0]        cpu_a,
   input  logic [`BBC_DW-1:0]            cpu_wdata,
   input  logic                          cpu_r_nw,
   input  logic                          cpu_clken,
   output bbc_mem_pkg::bus_region_e      region,
   output logic [`BBC_ROMSEL_W-1:0]      romsel
);

   logic romsel_we;

   // Memory map decode
   always_comb
   begin
      if (cpu_a < `BBC_ROM_BASE)
      begin
         region = bbc_mem_pkg::REGION_RAM;
      end
      else if (cpu_a < `BBC_MOS_BASE)
      begin
         region = bbc_mem_pkg::REGION_ROM;
      end
      else if ((cpu_a < `BBC_FRED_BASE) || (cpu_a[15:8] == 8'hFF))
      begin
         // MOS also owns the top page with the vectors
         region = bbc_mem_pkg::REGION_MOS;
      end
      else if ((cpu_a[15:8] == `BBC_SHEILA_PAGE) && (cpu_a[7:3] == 5'b00001))
      begin
         // SHEILA 0x08 to 0x0F
         region = bbc_mem_pkg::REGION_ACIA;
      end
      else if ((cpu_a[15:8] == `BBC_SHEILA_PAGE) && (cpu_a[7:4] == 4'h3))
      begin
         // SHEILA 0x30 to 0x3F
         region = bbc_mem_pkg::REGION_ROMSEL;
      end
      else
      begin
         region = bbc_mem_pkg::REGION_IO_OTHER;
      end
   end

   // Only a strobed CPU write to the latch loads it
   assign romsel_we = (region == bbc_mem_pkg::REGION_ROMSEL) && !cpu_r_nw && cpu_clken;

   // Paged ROM bank register
   always_ff @(posedge CLK32M_I or negedge reset_n)
   begin
      if (!reset_n)
      begin
         romsel <= '0;
      end
      else if (romsel_we)
      begin
         romsel <= cpu_wdata[`BBC_ROMSEL_W-1:0];
      end
   end

endmodule

/* logic/bbc_mem_pkg.sv */
package bbc_mem_pkg;

   // Region selected by the CPU address
   typedef enum logic [2:0]
   {
      REGION_RAM      = 3'd0,
      REGION_ROM      = 3'd1,
      REGION_MOS      = 3'd2,
      REGION_ACIA     = 3'd3,
      REGION_ROMSEL   = 3'd4,
      REGION_IO_OTHER = 3'd5
   } bus_region_e;

   // IC32 bits 5:4, selects where the screen restarts after the
   // hardware wrap at 0x8000
   typedef enum logic [1:0]
   {
      // Restart at 0x4000
      WRAP_MODE3   = 2'b00,
      // Restart at 0x6000
      WRAP_MODE6   = 2'b01,
      // Restart at 0x3000
      WRAP_MODE012 = 2'b10,
      // Restart at 0x5800
      WRAP_MODE45  = 2'b11
   } wrap_mode_e;

endpackage

/* include/bbc_mem_params.svh */
`ifndef BBC_MEM_PARAMS_SVH
`define BBC_MEM_PARAMS_SVH

// Bus and address widths
`define BBC_CPU_AW        16
`define BBC_DW            8
`define BBC_EXT_AW        18
`define BBC_MA_W          14
`define BBC_RA_W          5
`define BBC_DISP_AW       15
`define BBC_ROMSEL_W      4

// CPU memory map boundaries
`define BBC_ROM_BASE      16'h8000
`define BBC_MOS_BASE      16'hC000
`define BBC_FRED_BASE     16'hFC00

// SHEILA holds the on-board peripherals
`define BBC_SHEILA_PAGE   8'hFE

// ACIA stub, transmit data register empty
`define BBC_ACIA_STATUS   8'h02

// Screen wrap offsets added to MA bits 11:8 when MA bit 12 is set
`define BBC_WRAP_MODE3    4'd8
`define BBC_WRAP_MODE6    4'd12
`define BBC_WRAP_MODE012  4'd6
`define BBC_WRAP_MODE45   4'd11

`endif
